//--- bench/stat_tests.txt
# One command per line, all fields hex
# E events repeat | L parser fd_out dm2pcie | R addr valid data | W addr data | I cycles
R 00000000 1 00000000
R 00000001 1 00000000
R 00000002 1 00000000
R 00000003 1 00000000
R 00000004 1 00000000
R 00000005 1 00000000
R 00000006 1 00000000
R 00000007 1 00000000
R 00000008 1 00000000
R 00000009 1 00000000
I 6
E 20 5
E 10 3
E 01 7
E 08 2
E 0A 3
E 0C 4
E 0E 6
E 3D 1
I 4
R 00000000 1 00000006
R 00000001 1 00000004
R 00000009 1 00000008
I 2
R 00000002 1 00000010
R 00000003 1 00000002
R 00000004 1 00000003
R 00000005 1 00000005
L 0010 0100 0003
L 0025 0080 0007
L 0008 0200 0002
L 0001 0001 0001
I 4
R 00000006 1 00000025
R 00000007 1 00000200
R 00000008 1 00000007
R 0000000A 1 00000345
R 000000FF 1 00000345
R 04000000 0 00000000
R 3C000001 0 00000000
W 00000000 FFFFFFFF
W 00000006 00001234
I 4
R 00000000 1 00000006
R 00000006 1 00000025
R 00000009 1 00000008
I 6

//--- files.f
src/stat_pkg.sv
src/stat_event_counters.sv
src/stat_watermark.sv
src/stat_csr_slave.sv
src/stat_top.sv
bench/stat_tb_assert.sv
bench/stat_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= stat_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= sim failed
PASS_MSG  ?= sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "RESULT: FAIL"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "RESULT: FAIL (no verdict in $(LOG))"; exit 1; \
	else \
		echo "RESULT: PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/stat_tb.sv
`timescale 1ns/1ps

module stat_tb;
    import stat_pkg::*;

    localparam int LEVEL_W      = 16;
    localparam int CLK_HALF     = 4;
    localparam int RESET_CYCLES = 5;
    localparam int READ_LATENCY = 3;

    // One line of the test file
    typedef struct packed {
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
    } test_cmd_t;

    // Expected answer of one read and the cycle it is due
    typedef struct packed {
        logic [31:0] due;
        logic        valid;
        stat_word_t  data;
    } read_exp_t;

    logic                   clk_status = 1'b0;
    logic                   rst;
    stat_events_t           events;
    stat_levels_t           levels;
    logic [STAT_ADDR_W-1:0] status_addr;
    logic                   status_read;
    logic                   status_write;
    stat_word_t             status_writedata;
    stat_word_t             status_readdata;
    logic                   status_readdata_valid;

    test_cmd_t   cmds[$];
    read_exp_t   pending[$];
    read_exp_t   head;
    logic [31:0] cycle    = '0;
    logic        checking = 1'b0;
    logic        loaded   = 1'b0;
    int          limit    = 0;

    always #CLK_HALF clk_status = ~clk_status;

    always @(posedge clk_status) begin
        cycle <= cycle + 32'd1;
    end

    stat_top #(
        .LEVEL_W (LEVEL_W)
    ) i_stat_top (
        .clk_status            (clk_status),
        .rst                   (rst),
        .events                (events),
        .levels                (levels),
        .status_addr           (status_addr),
        .status_read           (status_read),
        .status_write          (status_write),
        .status_writedata      (status_writedata),
        .status_readdata       (status_readdata),
        .status_readdata_valid (status_readdata_valid)
    );

    bind stat_csr_slave stat_tb_assert i_stat_tb_assert (
        .clk_status            (clk_status),
        .rst                   (rst),
        .status_addr           (status_addr),
        .status_read           (status_read),
        .status_readdata_valid (status_readdata_valid)
    );

    //////////////////////////////
    // Checks
    //////////////////////////////
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_readdata(input stat_word_t got, input stat_word_t want);
        if (got !== want) begin
            stop_run($sformatf("Mismatch status_readdata: got %h, expected %h", got, want));
        end
    endtask

    task automatic check_valid(input logic got, input logic want);
        if (got !== want) begin
            stop_run($sformatf("Mismatch status_readdata_valid: got %h, expected %h",
                               got, want));
        end
    endtask

    // Every cycle either answers the oldest read or shows no valid
    always @(negedge clk_status) begin
        if (checking) begin
            if (pending.size() != 0 && pending[0].due == cycle) begin
                head = pending.pop_front();
                check_valid(status_readdata_valid, head.valid);
                if (head.valid) begin
                    check_readdata(status_readdata, head.data);
                end
            end else begin
                check_valid(status_readdata_valid, 1'b0);
            end
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    task automatic load_tests();
        int               fd;
        int               n;
        logic [7:0]       op;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      c;
        logic [8*128-1:0] rest;
        test_cmd_t        cmd;
        fd = $fopen("bench/stat_tests.txt", "r");
        if (fd == 0) begin
            stop_run("Could not open bench/stat_tests.txt");
        end
        while (1) begin
            n = $fscanf(fd, " %c", op);
            if (n != 1) begin
                break;
            end
            a = '0;
            b = '0;
            c = '0;
            case (op)
                "#": n = $fgets(rest, fd);
                "E", "W": begin
                    n = $fscanf(fd, "%h %h", a, b);
                    if (n != 2) stop_run("Test file line has too few fields");
                end
                "L", "R": begin
                    n = $fscanf(fd, "%h %h %h", a, b, c);
                    if (n != 3) stop_run("Test file line has too few fields");
                end
                "I": begin
                    n = $fscanf(fd, "%h", a);
                    if (n != 1) stop_run("Test file idle line has no count");
                end
                default: stop_run("Unknown command in test file");
            endcase
            if (op != "#") begin
                cmd.op = op;
                cmd.a  = a;
                cmd.b  = b;
                cmd.c  = c;
                cmds.push_back(cmd);
            end
        end
        $fclose(fd);
    endtask

    // Strobes drop back to idle on every new cycle while levels hold
    task automatic next_cycle();
        @(posedge clk_status);
        #1;
        events       = '0;
        status_read  = 1'b0;
        status_write = 1'b0;
    endtask

    task automatic run_command(input test_cmd_t cmd);
        read_exp_t entry;
        case (cmd.op)
            "E": begin
                repeat (cmd.b) begin
                    next_cycle();
                    events = stat_events_t'(cmd.a[5:0]);
                end
            end
            "L": begin
                next_cycle();
                levels.parser_lvl  = cmd.a[LEVEL_W_DEF-1:0];
                levels.fd_out_lvl  = cmd.b[LEVEL_W_DEF-1:0];
                levels.dm2pcie_lvl = cmd.c[LEVEL_W_DEF-1:0];
            end
            "R": begin
                next_cycle();
                status_read = 1'b1;
                status_addr = cmd.a[STAT_ADDR_W-1:0];
                entry.due   = cycle + READ_LATENCY;
                entry.valid = cmd.b[0];
                entry.data  = cmd.c;
                pending.push_back(entry);
            end
            "W": begin
                next_cycle();
                status_write     = 1'b1;
                status_addr      = cmd.a[STAT_ADDR_W-1:0];
                status_writedata = cmd.b;
            end
            "I": begin
                repeat (cmd.a) begin
                    next_cycle();
                end
            end
            default: stop_run("Unknown command reached the driver");
        endcase
    endtask

    //////////////////////////////
    // Run and verdict
    //////////////////////////////
    initial begin
        rst              = 1'b1;
        events           = '0;
        levels           = '0;
        status_addr      = '0;
        status_read      = 1'b0;
        status_write     = 1'b0;
        status_writedata = '0;

        load_tests();
        limit  = cmds.size() * 10 + 100;
        loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk_status);
        #1;
        rst      = 1'b0;
        checking = 1'b1;

        foreach (cmds[i]) begin
            run_command(cmds[i]);
        end

        // Let the last answers come out
        next_cycle();
        repeat (READ_LATENCY + 2) @(posedge clk_status);

        $display("sim passed");
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (limit) @(posedge clk_status);
        stop_run($sformatf("Run timed out after %0d clock cycles", limit));
    end

endmodule

//--- bench/stat_tb_assert.sv
`timescale 1ns/1ps

module stat_tb_assert (
    input logic                             clk_status,
    input logic                             rst,
    input logic [stat_pkg::STAT_ADDR_W-1:0] status_addr,
    input logic                             status_read,
    input logic                             status_readdata_valid
);
    import stat_pkg::*;

    logic other_block;

    assign other_block = status_read &&
                         (status_addr[STAT_ADDR_W-1 -: STAT_AWIDTH] != TOP_REG);

    // Answer comes three cycles after the strobe
    valid_after_read: assert property (
        @(posedge clk_status) disable iff (rst)
        status_readdata_valid |-> $past(status_read, 3)
    ) else $error("Read valid without a read strobe three cycles before");

    no_valid_after_reset: assert property (
        @(posedge clk_status)
        $fell(rst) |-> !status_readdata_valid ##1 !status_readdata_valid
                       ##1 !status_readdata_valid
    ) else $error("Read valid within three cycles of reset release");

    no_valid_other_block: assert property (
        @(posedge clk_status) disable iff (rst)
        other_block |-> ##3 !status_readdata_valid
    ) else $error("Read to another block gave a valid answer");

endmodule

//--- src/stat_top.sv
`timescale 1ns/1ps

module stat_top #(
    parameter int LEVEL_W = stat_pkg::LEVEL_W_DEF
) (
    input  logic                             clk_status,
    input  logic                             rst,

    // Event strobes and FIFO fill levels
    input  stat_pkg::stat_events_t           events,
    input  stat_pkg::stat_levels_t           levels,

    // Status bus
    input  logic [stat_pkg::STAT_ADDR_W-1:0] status_addr,
    input  logic                             status_read,
    input  logic                             status_write,
    input  stat_pkg::stat_word_t             status_writedata,
    output stat_pkg::stat_word_t             status_readdata,
    output logic                             status_readdata_valid
);
    import stat_pkg::*;

    stat_counts_t counts;
    stat_marks_t  marks;

    //////////////////////////////
    // Statistics
    //////////////////////////////
    stat_event_counters i_stat_event_counters (
        .clk_status (clk_status),
        .rst        (rst),
        .events     (events),
        .counts     (counts)
    );

    stat_watermark #(
        .LEVEL_W (LEVEL_W)
    ) i_stat_watermark (
        .clk_status (clk_status),
        .rst        (rst),
        .levels     (levels),
        .marks      (marks)
    );

    //////////////////////////////
    // Read port
    //////////////////////////////
    stat_csr_slave i_stat_csr_slave (
        .clk_status            (clk_status),
        .rst                   (rst),
        .counts                (counts),
        .marks                 (marks),
        .status_addr           (status_addr),
        .status_read           (status_read),
        .status_write          (status_write),
        .status_writedata      (status_writedata),
        .status_readdata       (status_readdata),
        .status_readdata_valid (status_readdata_valid)
    );

endmodule

//--- src/stat_csr_slave.sv
`timescale 1ns/1ps

module stat_csr_slave (
    input  logic                             clk_status,
    input  logic                             rst,
    input  stat_pkg::stat_counts_t           counts,
    input  stat_pkg::stat_marks_t            marks,
    input  logic [stat_pkg::STAT_ADDR_W-1:0] status_addr,
    input  logic                             status_read,
    input  logic                             status_write,
    input  stat_pkg::stat_word_t             status_writedata,
    output stat_pkg::stat_word_t             status_readdata,
    output logic                             status_readdata_valid
);
    import stat_pkg::*;

    logic                   read_r;
    stat_idx_t              idx_r;
    logic [STAT_AWIDTH-1:0] sel_r;

    logic                   hit;
    stat_word_t             map_word;

    logic                   valid_top;
    stat_word_t             data_top;

    //////////////////////////////
    // Stage 1: bus capture
    //////////////////////////////
    always_ff @(posedge clk_status) begin
        if (rst) begin
            read_r <= 1'b0;
        end else begin
            read_r <= status_read;
        end
    end

    always_ff @(posedge clk_status) begin
        idx_r <= status_addr[7:0];
        sel_r <= status_addr[STAT_ADDR_W-1 -: STAT_AWIDTH];
    end

    //////////////////////////////
    // Stage 2: decode and select
    //////////////////////////////
    assign hit = read_r && (sel_r == TOP_REG);

    always_comb begin
        case (idx_r)
            IDX_IN_PKT:      map_word = counts.in_pkt;
            IDX_OUT_PKT:     map_word = counts.out_pkt;
            IDX_META:        map_word = counts.meta;
            IDX_PKT_ETH:     map_word = counts.pkt_eth;
            IDX_PKT_DROP:    map_word = counts.pkt_drop;
            IDX_PKT_PCIE:    map_word = counts.pkt_pcie;
            IDX_MAX_PARSER:  map_word = marks.max_parser;
            IDX_MAX_FD_OUT:  map_word = marks.max_fd_out;
            IDX_MAX_DM2PCIE: map_word = marks.max_dm2pcie;
            IDX_DMA_PKT:     map_word = counts.dma_pkt;
            default:         map_word = REG_UNMAPPED;
        endcase
    end

    always_ff @(posedge clk_status) begin
        if (rst) begin
            valid_top <= 1'b0;
        end else begin
            valid_top <= hit;
        end
    end

    always_ff @(posedge clk_status) begin
        if (hit) begin
            data_top <= map_word;
        end
    end

    //////////////////////////////
    // Stage 3: output
    //////////////////////////////
    always_ff @(posedge clk_status) begin
        if (rst) begin
            status_readdata_valid <= 1'b0;
        end else begin
            status_readdata_valid <= valid_top;
        end
    end

    // Data holds between answers
    always_ff @(posedge clk_status) begin
        if (valid_top) begin
            status_readdata <= data_top;
        end
    end

endmodule

//--- src/stat_watermark.sv
`timescale 1ns/1ps

module stat_watermark #(
    parameter int LEVEL_W = stat_pkg::LEVEL_W_DEF
) (
    input  logic                   clk_status,
    input  logic                   rst,
    input  stat_pkg::stat_levels_t levels,
    output stat_pkg::stat_marks_t  marks
);
    import stat_pkg::*;

    localparam int NUM_LVL = 3;

    logic [LEVEL_W-1:0] lvl     [NUM_LVL];
    logic [LEVEL_W-1:0] max_lvl [NUM_LVL];

    // Levels resized to the tracked width
    assign lvl[0] = LEVEL_W'(levels.parser_lvl);
    assign lvl[1] = LEVEL_W'(levels.fd_out_lvl);
    assign lvl[2] = LEVEL_W'(levels.dm2pcie_lvl);

    // Running maximum, follows only a higher level
    always_ff @(posedge clk_status) begin
        for (int i = 0; i < NUM_LVL; i++) begin
            if (rst) begin
                max_lvl[i] <= '0;
            end else if (lvl[i] > max_lvl[i]) begin
                max_lvl[i] <= lvl[i];
            end
        end
    end

    // Zero-extended onto the status word
    assign marks.max_parser  = stat_word_t'(max_lvl[0]);
    assign marks.max_fd_out  = stat_word_t'(max_lvl[1]);
    assign marks.max_dm2pcie = stat_word_t'(max_lvl[2]);

endmodule

//--- src/stat_event_counters.sv
`timescale 1ns/1ps

module stat_event_counters (
    input  logic                   clk_status,
    input  logic                   rst,
    input  stat_pkg::stat_events_t events,
    output stat_pkg::stat_counts_t counts
);
    import stat_pkg::*;

    logic cls_eth;
    logic cls_drop;
    logic cls_pcie;

    //////////////////////////////
    // Class decode
    //////////////////////////////
    always_comb begin
        cls_eth  = 1'b0;
        cls_drop = 1'b0;
        cls_pcie = 1'b0;
        if (events.meta_valid) begin
            case (events.meta_flags)
                PKT_ETH:  cls_eth  = 1'b1;
                PKT_DROP: cls_drop = 1'b1;
                PKT_PCIE: cls_pcie = 1'b1;
                // Reserved class only counts in the total
                default:  ;
            endcase
        end
    end

    //////////////////////////////
    // Counters
    //////////////////////////////
    always_ff @(posedge clk_status) begin
        if (rst) begin
            counts <= '0;
        end else begin
            if (events.in_eop) begin
                counts.in_pkt <= counts.in_pkt + 32'd1;
            end

            if (events.out_eop) begin
                counts.out_pkt <= counts.out_pkt + 32'd1;
            end

            if (events.meta_valid) begin
                counts.meta <= counts.meta + 32'd1;
            end

            if (cls_eth) begin
                counts.pkt_eth <= counts.pkt_eth + 32'd1;
            end

            if (cls_drop) begin
                counts.pkt_drop <= counts.pkt_drop + 32'd1;
            end

            if (cls_pcie) begin
                counts.pkt_pcie <= counts.pkt_pcie + 32'd1;
            end

            // One per ring-buffer update
            if (events.dma_update) begin
                counts.dma_pkt <= counts.dma_pkt + 32'd1;
            end
        end
    end

endmodule

//--- src/stat_pkg.sv
package stat_pkg;

    // Status data word, also the width of every counter
    typedef logic [31:0] stat_word_t;

    //////////////////////////////
    // Status bus
    //////////////////////////////
    localparam int STAT_ADDR_W = 30;

    // Block-select field at the top of the address
    localparam int STAT_AWIDTH = 4;
    localparam logic [STAT_AWIDTH-1:0] TOP_REG = 4'h0;

    typedef logic [7:0] stat_idx_t;

    localparam stat_word_t REG_UNMAPPED = 32'h0000_0345;

    //////////////////////////////
    // Register map
    //////////////////////////////
    localparam stat_idx_t IDX_IN_PKT      = 8'd0;
    localparam stat_idx_t IDX_OUT_PKT     = 8'd1;
    localparam stat_idx_t IDX_META        = 8'd2;
    localparam stat_idx_t IDX_PKT_ETH     = 8'd3;
    localparam stat_idx_t IDX_PKT_DROP    = 8'd4;
    localparam stat_idx_t IDX_PKT_PCIE    = 8'd5;
    localparam stat_idx_t IDX_MAX_PARSER  = 8'd6;
    localparam stat_idx_t IDX_MAX_FD_OUT  = 8'd7;
    localparam stat_idx_t IDX_MAX_DM2PCIE = 8'd8;
    localparam stat_idx_t IDX_DMA_PKT     = 8'd9;

    // Packet class carried with the metadata
    typedef enum logic [1:0] {
        PKT_ETH  = 2'd0,
        PKT_DROP = 2'd1,
        PKT_PCIE = 2'd2,
        PKT_RSVD = 2'd3
    } pkt_flags_t;

    typedef struct packed {
        logic       in_eop;
        logic       out_eop;
        logic       meta_valid;
        pkt_flags_t meta_flags;
        logic       dma_update;
    } stat_events_t;

    localparam int LEVEL_W_DEF = 16;

    // FIFO fill levels
    typedef struct packed {
        logic [LEVEL_W_DEF-1:0] parser_lvl;
        logic [LEVEL_W_DEF-1:0] fd_out_lvl;
        logic [LEVEL_W_DEF-1:0] dm2pcie_lvl;
    } stat_levels_t;

    typedef struct packed {
        stat_word_t in_pkt;
        stat_word_t out_pkt;
        stat_word_t meta;
        stat_word_t pkt_eth;
        stat_word_t pkt_drop;
        stat_word_t pkt_pcie;
        stat_word_t dma_pkt;
    } stat_counts_t;

    typedef struct packed {
        stat_word_t max_parser;
        stat_word_t max_fd_out;
        stat_word_t max_dm2pcie;
    } stat_marks_t;

endpackage
